//--- source/branch_resolve.sv
// Branch resolution in X
// Evaluates the branch condition and selects the next PC
`default_nettype none

module branch_resolve (
  input  logic                    x_valid,
  input  pipe_ctrl_pkg::br_type_t br_type,
  input  logic                    cond_eq,
  input  logic                    cond_neg,
  input  logic                    cond_zero,
  output logic                    br_taken,
  output pipe_ctrl_pkg::pc_sel_t  pc_sel
);
  import pipe_ctrl_pkg::*;

  logic cond;

  always_comb begin
    case (br_type)
      BR_NE:   cond = !cond_eq;
      BR_EQ:   cond = cond_eq;
      BR_GTZ:  cond = !cond_zero && !cond_neg;
      BR_LTZ:  cond = cond_neg;
      BR_GEZ:  cond = cond_zero || !cond_neg;
      BR_LEZ:  cond = cond_zero || cond_neg;
      default: cond = 1'b0;  // Not a branch
    endcase
  end

  assign br_taken = x_valid && cond;
  assign pc_sel   = br_taken ? PC_BRANCH : PC_PLUS4;

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
// Data hazard unit
// Picks the rs/rt bypass source and stalls D when no bypass is possible
`default_nettype none

module hazard_unit (
  input  logic                     d_valid,
  input  pipe_ctrl_pkg::reg_addr_t rs,
  input  pipe_ctrl_pkg::reg_addr_t rt,
  input  logic                     rs_en,
  input  logic                     rt_en,
  input  logic                     x_val,
  input  logic                     x_rf_wen,
  input  pipe_ctrl_pkg::reg_addr_t x_waddr,
  input  logic                     x_is_load,
  input  logic                     m_val,
  input  logic                     m_rf_wen,
  input  pipe_ctrl_pkg::reg_addr_t m_waddr,
  input  logic                     w_val,
  input  logic                     w_rf_wen,
  input  pipe_ctrl_pkg::reg_addr_t w_waddr,
  output pipe_ctrl_pkg::bypass_t   bypass_rs,
  output pipe_ctrl_pkg::bypass_t   bypass_rt,
  output logic                     stall_hazard
);
  import pipe_ctrl_pkg::*;

  logic rs_x;
  logic rs_m;
  logic rs_w;
  logic rt_x;
  logic rt_m;
  logic rt_w;

  // Live writer targets this source, r0 excluded
  function automatic logic hit(input logic src_en, input logic wr_en,
                               input reg_addr_t waddr, input reg_addr_t src);
    return src_en && wr_en && (waddr == src) && (waddr != REG_ZERO);
  endfunction

  // Youngest writer wins
  function automatic bypass_t pick(input logic in_x, input logic in_m);
    if (in_x && !x_is_load) return BYP_X;
    if (!in_x && in_m) return BYP_M;
    return BYP_NONE;
  endfunction

  // Load in X has no data yet, W is not on a bypass path
  function automatic logic blocked(input logic in_x, input logic in_m, input logic in_w);
    return (in_x && x_is_load) || (!in_x && !in_m && in_w);
  endfunction

  assign rs_x = hit(d_valid && rs_en, x_val && x_rf_wen, x_waddr, rs);
  assign rs_m = hit(d_valid && rs_en, m_val && m_rf_wen, m_waddr, rs);
  assign rs_w = hit(d_valid && rs_en, w_val && w_rf_wen, w_waddr, rs);
  assign rt_x = hit(d_valid && rt_en, x_val && x_rf_wen, x_waddr, rt);
  assign rt_m = hit(d_valid && rt_en, m_val && m_rf_wen, m_waddr, rt);
  assign rt_w = hit(d_valid && rt_en, w_val && w_rf_wen, w_waddr, rt);

  assign bypass_rs    = pick(rs_x, rs_m);
  assign bypass_rt    = pick(rt_x, rt_m);
  assign stall_hazard = blocked(rs_x, rs_m, rs_w) || blocked(rt_x, rt_m, rt_w);

endmodule

`default_nettype wire

//--- source/inst_decoder.sv
// Instruction decoder
// Table lookup from the D-stage instruction to its control word
`default_nettype none

module inst_decoder (
  input  pipe_ctrl_pkg::inst_t      inst,
  input  logic                      d_valid,
  output pipe_ctrl_pkg::ctrl_word_t ctrl
);
  import pipe_ctrl_pkg::*;

  logic [5:0] opcode;
  logic [5:0] func;
  reg_addr_t  rt;
  reg_addr_t  rd;

  assign opcode = inst[OPC_MSB:OPC_LSB];
  assign func   = inst[FUNC_MSB:FUNC_LSB];
  assign rt     = inst[RT_MSB:RT_LSB];
  assign rd     = inst[RD_MSB:RD_LSB];

  // One row of the control table
  function automatic ctrl_word_t cs(
    input logic      val,
    input logic      rs_en,
    input logic      rt_en,
    input op1_sel_t  op1_sel,
    input alu_fn_t   alu_fn,
    input br_type_t  br_type,
    input mem_type_t mem_type,
    input logic      wb_from_mem,
    input logic      rf_wen,
    input reg_addr_t rf_waddr
  );
    ctrl_word_t c;
    c.inst_val    = val;
    c.rs_en       = rs_en;
    c.rt_en       = rt_en;
    c.op1_sel     = op1_sel;
    c.alu_fn      = alu_fn;
    c.br_type     = br_type;
    c.mem_type    = mem_type;
    c.wb_from_mem = wb_from_mem;
    c.rf_wen      = rf_wen;
    c.rf_waddr    = rf_waddr;
    return c;
  endfunction

  always_comb begin
    // Unknown or empty slot does nothing
    ctrl = cs(N, N, N, OP1_REG, ALU_ADD, BR_NONE, MEM_NONE, N, N, REG_ZERO);
    if (d_valid) begin
      case (opcode)
        OPC_SPECIAL: begin
          //                 val rs rt op1      alu      br       mem       wbm wen wa
          case (func)
            FUNC_ADDU: ctrl = cs(Y, Y, Y, OP1_REG, ALU_ADD, BR_NONE, MEM_NONE, N, Y, rd);
            FUNC_SUBU: ctrl = cs(Y, Y, Y, OP1_REG, ALU_SUB, BR_NONE, MEM_NONE, N, Y, rd);
            FUNC_AND:  ctrl = cs(Y, Y, Y, OP1_REG, ALU_AND, BR_NONE, MEM_NONE, N, Y, rd);
            FUNC_OR:   ctrl = cs(Y, Y, Y, OP1_REG, ALU_OR,  BR_NONE, MEM_NONE, N, Y, rd);
            FUNC_XOR:  ctrl = cs(Y, Y, Y, OP1_REG, ALU_XOR, BR_NONE, MEM_NONE, N, Y, rd);
            FUNC_NOR:  ctrl = cs(Y, Y, Y, OP1_REG, ALU_NOR, BR_NONE, MEM_NONE, N, Y, rd);
            FUNC_SLT:  ctrl = cs(Y, Y, Y, OP1_REG, ALU_LTS, BR_NONE, MEM_NONE, N, Y, rd);
            FUNC_SLTU: ctrl = cs(Y, Y, Y, OP1_REG, ALU_LTU, BR_NONE, MEM_NONE, N, Y, rd);
            default: ;
          endcase
        end
        OPC_ADDIU: ctrl = cs(Y, Y, N, OP1_SIMM, ALU_ADD, BR_NONE, MEM_NONE, N, Y, rt);
        OPC_ORI:   ctrl = cs(Y, Y, N, OP1_ZIMM, ALU_OR,  BR_NONE, MEM_NONE, N, Y, rt);
        OPC_ANDI:  ctrl = cs(Y, Y, N, OP1_ZIMM, ALU_AND, BR_NONE, MEM_NONE, N, Y, rt);
        OPC_LUI:   ctrl = cs(Y, N, N, OP1_ZIMM, ALU_LUI, BR_NONE, MEM_NONE, N, Y, rt);
        OPC_LW:    ctrl = cs(Y, Y, N, OP1_SIMM, ALU_ADD, BR_NONE, MEM_LOAD, Y, Y, rt);
        OPC_SW:    ctrl = cs(Y, Y, Y, OP1_SIMM, ALU_ADD, BR_NONE, MEM_STORE, N, N, REG_ZERO);
        OPC_BNE:   ctrl = cs(Y, Y, Y, OP1_REG, ALU_SUB, BR_NE, MEM_NONE, N, N, REG_ZERO);
        OPC_BEQ:   ctrl = cs(Y, Y, Y, OP1_REG, ALU_SUB, BR_EQ, MEM_NONE, N, N, REG_ZERO);
        OPC_BGTZ:  ctrl = cs(Y, Y, N, OP1_REG, ALU_ADD, BR_GTZ, MEM_NONE, N, N, REG_ZERO);
        OPC_BLEZ:  ctrl = cs(Y, Y, N, OP1_REG, ALU_ADD, BR_LEZ, MEM_NONE, N, N, REG_ZERO);
        OPC_REGIMM: begin
          if (rt == RT_BLTZ) begin
            ctrl = cs(Y, Y, N, OP1_REG, ALU_ADD, BR_LTZ, MEM_NONE, N, N, REG_ZERO);
          end else if (rt == RT_BGEZ) begin
            ctrl = cs(Y, Y, N, OP1_REG, ALU_ADD, BR_GEZ, MEM_NONE, N, N, REG_ZERO);
          end
        end
        default: ;
      endcase
    end
  end

  // A store never writes the register file
  a_store_no_wen: assert final (!(ctrl.rf_wen && ctrl.mem_type == MEM_STORE));

endmodule

`default_nettype wire

//--- source/pipe_ctrl_pkg.sv
// Pipeline control package
// Instruction encodings, field positions and the per-stage payload types
`default_nettype none

package pipe_ctrl_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;

  localparam reg_addr_t REG_ZERO = 5'd0;  // Never written

  // Control table flags
  localparam logic Y = 1'b1;
  localparam logic N = 1'b0;

  //------------------------------
  // Instruction fields
  //------------------------------
  localparam int OPC_MSB  = 31;
  localparam int OPC_LSB  = 26;
  localparam int RS_MSB   = 25;
  localparam int RS_LSB   = 21;
  localparam int RT_MSB   = 20;
  localparam int RT_LSB   = 16;
  localparam int RD_MSB   = 15;
  localparam int RD_LSB   = 11;
  localparam int FUNC_MSB = 5;
  localparam int FUNC_LSB = 0;

  localparam logic [5:0] OPC_SPECIAL = 6'h00;
  localparam logic [5:0] OPC_REGIMM  = 6'h01;  // bltz / bgez, picked by rt
  localparam logic [5:0] OPC_BEQ     = 6'h04;
  localparam logic [5:0] OPC_BNE     = 6'h05;
  localparam logic [5:0] OPC_BLEZ    = 6'h06;
  localparam logic [5:0] OPC_BGTZ    = 6'h07;
  localparam logic [5:0] OPC_ADDIU   = 6'h09;
  localparam logic [5:0] OPC_ANDI    = 6'h0c;
  localparam logic [5:0] OPC_ORI     = 6'h0d;
  localparam logic [5:0] OPC_LUI     = 6'h0f;
  localparam logic [5:0] OPC_LW      = 6'h23;
  localparam logic [5:0] OPC_SW      = 6'h2b;

  // Func codes under OPC_SPECIAL
  localparam logic [5:0] FUNC_ADDU = 6'h21;
  localparam logic [5:0] FUNC_SUBU = 6'h23;
  localparam logic [5:0] FUNC_AND  = 6'h24;
  localparam logic [5:0] FUNC_OR   = 6'h25;
  localparam logic [5:0] FUNC_XOR  = 6'h26;
  localparam logic [5:0] FUNC_NOR  = 6'h27;
  localparam logic [5:0] FUNC_SLT  = 6'h2a;
  localparam logic [5:0] FUNC_SLTU = 6'h2b;

  localparam reg_addr_t RT_BLTZ = 5'd0;
  localparam reg_addr_t RT_BGEZ = 5'd1;

  // Data memory request type
  localparam logic [2:0] MEM_REQ_READ  = 3'd0;
  localparam logic [2:0] MEM_REQ_WRITE = 3'd1;

  //------------------------------
  // Control encodings
  //------------------------------
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_NOR = 4'd5,
    ALU_LTS = 4'd6,
    ALU_LTU = 4'd7,
    ALU_LUI = 4'd8
  } alu_fn_t;

  typedef enum logic [1:0] {OP1_REG, OP1_SIMM, OP1_ZIMM} op1_sel_t;

  typedef enum logic [2:0] {
    BR_NONE, BR_NE, BR_EQ, BR_GTZ, BR_LTZ, BR_GEZ, BR_LEZ
  } br_type_t;

  typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_type_t;
  typedef enum logic [1:0] {BYP_NONE, BYP_X, BYP_M} bypass_t;
  typedef enum logic       {PC_PLUS4, PC_BRANCH} pc_sel_t;

  //------------------------------
  // Stage payloads
  //------------------------------
  typedef struct packed {
    logic      inst_val;
    logic      rs_en;
    logic      rt_en;
    op1_sel_t  op1_sel;
    alu_fn_t   alu_fn;
    br_type_t  br_type;
    mem_type_t mem_type;
    logic      wb_from_mem;
    logic      rf_wen;
    reg_addr_t rf_waddr;
  } ctrl_word_t;

  typedef struct packed {
    alu_fn_t   alu_fn;
    br_type_t  br_type;
    mem_type_t mem_type;
    logic      wb_from_mem;
    logic      rf_wen;
    reg_addr_t rf_waddr;
  } x_payload_t;

  typedef struct packed {
    mem_type_t mem_type;
    logic      wb_from_mem;
    logic      rf_wen;
    reg_addr_t rf_waddr;
  } m_payload_t;

  typedef struct packed {
    logic      rf_wen;
    reg_addr_t rf_waddr;
  } w_payload_t;

  // F and D carry nothing of their own
  typedef struct packed {
    logic unused;
  } empty_payload_t;

endpackage

`default_nettype wire

//--- source/pipe_stage.sv
// Pipeline stage control with valid bit and payload register
// Valid moves forward, stall and squash move backward
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     prev_val,      // From the earlier stage
  input  logic     prev_stall,    // From the later stage
  input  logic     prev_squash,   // From the later stage
  input  logic     stall_here,
  input  logic     squash_here,
  input  payload_t payload_in,
  output logic     reg_en,
  output logic     val,
  output payload_t payload_out,
  output logic     next_val,      // To the later stage
  output logic     next_stall,    // To the earlier stage
  output logic     next_squash    // To the earlier stage
);

  logic stall;

  // Own stall is dropped once the item here is squashed
  assign stall = prev_stall || (val && stall_here && !prev_squash);

  assign reg_en      = !stall;
  assign next_val    = val && !stall && !prev_squash;
  assign next_stall  = stall;
  assign next_squash = prev_squash || squash_here;

  always_ff @(posedge clk) begin
    if (reset) begin
      val <= 1'b0;
    end else if (reg_en) begin
      val <= prev_val;  // Bubble when the earlier stage holds
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en) begin
      payload_out <= payload_in;
    end
  end

  a_next_val_needs_val: assert property (
    @(posedge clk) disable iff (reset) next_val |-> val
  );

endmodule

`default_nettype wire

//--- source/proc_ctrl.sv
// Five-stage pipeline control with bypassing
// Sequences F/D/X/M/W, resolves hazards and drives the memory handshakes
`default_nettype none

module proc_ctrl (
  input  logic                     clk,
  input  logic                     reset,

  // Instruction memory
  output logic                     imemreq_val,
  input  logic                     imemreq_rdy,
  input  logic                     imemresp_val,
  output logic                     imemresp_rdy,
  output logic                     imemresp_drop,

  // Data memory
  output logic                     dmemreq_val,
  input  logic                     dmemreq_rdy,
  output logic [2:0]               dmemreq_type,
  input  logic                     dmemresp_val,
  output logic                     dmemresp_rdy,

  // Datapath controls
  output pipe_ctrl_pkg::pc_sel_t   pc_sel,
  output logic                     reg_en_f,
  output logic                     reg_en_d,
  output logic                     reg_en_x,
  output logic                     reg_en_m,
  output logic                     reg_en_w,
  output pipe_ctrl_pkg::op1_sel_t  op1_sel_d,
  output pipe_ctrl_pkg::alu_fn_t   alu_fn_x,
  output logic                     wb_from_mem_m,
  output logic                     rf_wen_w,
  output pipe_ctrl_pkg::reg_addr_t rf_waddr_w,
  output pipe_ctrl_pkg::bypass_t   bypass_rs,
  output pipe_ctrl_pkg::bypass_t   bypass_rt,

  // Datapath status
  input  pipe_ctrl_pkg::inst_t     inst_d,
  input  logic                     br_cond_eq_x,
  input  logic                     br_cond_neg_x,
  input  logic                     br_cond_zero_x
);
  import pipe_ctrl_pkg::*;

  ctrl_word_t ctrl_d;
  x_payload_t x_in;
  x_payload_t x_q;
  m_payload_t m_in;
  m_payload_t m_q;
  w_payload_t w_in;
  w_payload_t w_q;

  logic val_d;
  logic val_x;
  logic val_m;
  logic val_w;
  logic val_fd;
  logic val_dx;
  logic val_xm;
  logic val_mw;
  logic stall_pf;
  logic stall_fd;
  logic stall_dx;
  logic stall_xm;
  logic stall_mw;
  logic squash_fd;
  logic squash_dx;
  logic squash_xm;
  logic squash_mw;
  logic reg_en_f_stage;
  logic stall_imem_f;
  logic stall_hazard_d;
  logic dmem_op_x;
  logic dmem_op_m;
  logic br_taken_x;
  reg_addr_t rs_d;
  reg_addr_t rt_d;

  //------------------------------
  // F stage
  //------------------------------
  assign imemreq_val   = !stall_pf;
  assign imemresp_rdy  = !stall_fd;
  assign imemresp_drop = squash_fd && !stall_fd;  // Squashed fetch is thrown away
  assign stall_imem_f  = !imemresp_val && !imemresp_drop;
  assign reg_en_f      = reg_en_f_stage && imemreq_rdy;  // PC moves on accepted fetch

  pipe_stage #(.payload_t(empty_payload_t)) u_stage_f (
    .clk (clk), .reset (reset),
    .prev_val (imemreq_rdy), .prev_stall (stall_fd), .prev_squash (squash_fd),
    .stall_here (stall_imem_f), .squash_here (1'b0),
    .payload_in ('0), .payload_out (),
    .reg_en (reg_en_f_stage), .val (),
    .next_val (val_fd), .next_stall (stall_pf), .next_squash ()
  );

  //------------------------------
  // D stage
  //------------------------------
  assign rs_d = inst_d[RS_MSB:RS_LSB];
  assign rt_d = inst_d[RT_MSB:RT_LSB];

  inst_decoder u_decoder (.inst (inst_d), .d_valid (val_d), .ctrl (ctrl_d));

  hazard_unit u_hazard (
    .d_valid (val_d), .rs (rs_d), .rt (rt_d),
    .rs_en (ctrl_d.rs_en), .rt_en (ctrl_d.rt_en),
    .x_val (val_x), .x_rf_wen (x_q.rf_wen), .x_waddr (x_q.rf_waddr),
    .x_is_load (x_q.mem_type == MEM_LOAD),
    .m_val (val_m), .m_rf_wen (m_q.rf_wen), .m_waddr (m_q.rf_waddr),
    .w_val (val_w), .w_rf_wen (w_q.rf_wen), .w_waddr (w_q.rf_waddr),
    .bypass_rs (bypass_rs), .bypass_rt (bypass_rt), .stall_hazard (stall_hazard_d)
  );

  pipe_stage #(.payload_t(empty_payload_t)) u_stage_d (
    .clk (clk), .reset (reset),
    .prev_val (val_fd), .prev_stall (stall_dx), .prev_squash (squash_dx),
    .stall_here (stall_hazard_d), .squash_here (1'b0),
    .payload_in ('0), .payload_out (),
    .reg_en (reg_en_d), .val (val_d),
    .next_val (val_dx), .next_stall (stall_fd), .next_squash (squash_fd)
  );

  assign op1_sel_d = ctrl_d.op1_sel;
  assign x_in = '{alu_fn: ctrl_d.alu_fn, br_type: ctrl_d.br_type,
                  mem_type: ctrl_d.mem_type, wb_from_mem: ctrl_d.wb_from_mem,
                  rf_wen: ctrl_d.rf_wen, rf_waddr: ctrl_d.rf_waddr};

  //------------------------------
  // X stage
  //------------------------------
  branch_resolve u_branch (
    .x_valid (val_x), .br_type (x_q.br_type),
    .cond_eq (br_cond_eq_x), .cond_neg (br_cond_neg_x), .cond_zero (br_cond_zero_x),
    .br_taken (br_taken_x), .pc_sel (pc_sel)
  );

  assign dmem_op_x    = val_x && (x_q.mem_type != MEM_NONE);
  assign dmemreq_val  = dmem_op_x && !stall_xm;
  assign dmemreq_type = (x_q.mem_type == MEM_STORE) ? MEM_REQ_WRITE : MEM_REQ_READ;

  pipe_stage #(.payload_t(x_payload_t)) u_stage_x (
    .clk (clk), .reset (reset),
    .prev_val (val_dx), .prev_stall (stall_xm), .prev_squash (squash_xm),
    .stall_here (dmem_op_x && !dmemreq_rdy), .squash_here (br_taken_x),
    .payload_in (x_in), .payload_out (x_q),
    .reg_en (reg_en_x), .val (val_x),
    .next_val (val_xm), .next_stall (stall_dx), .next_squash (squash_dx)
  );

  assign alu_fn_x = x_q.alu_fn;
  assign m_in = '{mem_type: x_q.mem_type, wb_from_mem: x_q.wb_from_mem,
                  rf_wen: x_q.rf_wen, rf_waddr: x_q.rf_waddr};

  //------------------------------
  // M and W stages
  //------------------------------
  assign dmem_op_m    = val_m && (m_q.mem_type != MEM_NONE);
  assign dmemresp_rdy = dmem_op_m && !stall_mw;

  pipe_stage #(.payload_t(m_payload_t)) u_stage_m (
    .clk (clk), .reset (reset),
    .prev_val (val_xm), .prev_stall (stall_mw), .prev_squash (squash_mw),
    .stall_here (dmem_op_m && !dmemresp_val), .squash_here (1'b0),
    .payload_in (m_in), .payload_out (m_q),
    .reg_en (reg_en_m), .val (val_m),
    .next_val (val_mw), .next_stall (stall_xm), .next_squash (squash_xm)
  );

  assign wb_from_mem_m = m_q.wb_from_mem;
  assign w_in = '{rf_wen: m_q.rf_wen, rf_waddr: m_q.rf_waddr};

  pipe_stage #(.payload_t(w_payload_t)) u_stage_w (
    .clk (clk), .reset (reset),
    .prev_val (val_mw), .prev_stall (1'b0), .prev_squash (1'b0),
    .stall_here (1'b0), .squash_here (1'b0),
    .payload_in (w_in), .payload_out (w_q),
    .reg_en (reg_en_w), .val (val_w),
    .next_val (), .next_stall (stall_mw), .next_squash (squash_mw)
  );

  assign rf_wen_w   = val_w && w_q.rf_wen;
  assign rf_waddr_w = w_q.rf_waddr;

  a_dmemreq_from_valid_x: assert property (
    @(posedge clk) disable iff (reset) dmemreq_val |-> val_x
  );

  a_drop_not_stalled: assert property (
    @(posedge clk) disable iff (reset) imemresp_drop |-> !stall_fd
  );

endmodule

`default_nettype wire

//--- verif/proc_ctrl_tb.sv
// Testbench for the five-stage pipeline control unit
// Replays per-cycle stimulus from a vector file and checks the control outputs
`default_nettype none

module proc_ctrl_tb;
  import pipe_ctrl_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int DRIVE_DELAY   = 2;
  localparam int RESET_CYCLES  = 10;
  localparam int MAX_VECTORS   = 64;
  localparam int TIMEOUT_SLACK = 20;

  localparam logic [3:0] ALU_EMPTY = 4'hf;  // Vector marker, X holds a bubble

  // Inputs of one vector line
  typedef struct packed {
    logic  imemreq_rdy;
    logic  imemresp_val;
    logic  dmemreq_rdy;
    logic  dmemresp_val;
    inst_t inst;
    logic  cond_eq;
    logic  cond_neg;
    logic  cond_zero;
  } stim_t;

  // Expected outputs of one vector line
  typedef struct packed {
    logic       pc_sel;
    logic       reg_en_d;
    logic [3:0] alu_fn;
    logic [1:0] bypass_rs;
    logic [1:0] bypass_rt;
    logic       dmemreq_val;
    logic       rf_wen;
    reg_addr_t  rf_waddr;
  } expect_t;

  logic      clk;
  logic      reset;
  logic      imemreq_val;
  logic      imemreq_rdy;
  logic      imemresp_val;
  logic      imemresp_rdy;
  logic      imemresp_drop;
  logic      dmemreq_val;
  logic      dmemreq_rdy;
  logic [2:0] dmemreq_type;
  logic      dmemresp_val;
  logic      dmemresp_rdy;
  pc_sel_t   pc_sel;
  logic      reg_en_f;
  logic      reg_en_d;
  logic      reg_en_x;
  logic      reg_en_m;
  logic      reg_en_w;
  op1_sel_t  op1_sel_d;
  alu_fn_t   alu_fn_x;
  logic      wb_from_mem_m;
  logic      rf_wen_w;
  reg_addr_t rf_waddr_w;
  bypass_t   bypass_rs;
  bypass_t   bypass_rt;
  inst_t     inst_d;
  logic      br_cond_eq_x;
  logic      br_cond_neg_x;
  logic      br_cond_zero_x;

  stim_t   stim_mem [MAX_VECTORS];
  expect_t exp_mem [MAX_VECTORS];
  string   name_mem [MAX_VECTORS];
  int      num_vectors;
  int      cur_vector;
  int      error_count;
  int      check_count;
  int      timeout_limit;
  int      cycle_count = 0;

  // Shadow of the instructions held in X and M
  inst_t   shadow_x_inst;
  inst_t   shadow_m_inst;
  logic    shadow_m_valid;

  proc_ctrl u_proc_ctrl (
    .clk (clk), .reset (reset),
    .imemreq_val (imemreq_val), .imemreq_rdy (imemreq_rdy),
    .imemresp_val (imemresp_val), .imemresp_rdy (imemresp_rdy),
    .imemresp_drop (imemresp_drop),
    .dmemreq_val (dmemreq_val), .dmemreq_rdy (dmemreq_rdy),
    .dmemreq_type (dmemreq_type),
    .dmemresp_val (dmemresp_val), .dmemresp_rdy (dmemresp_rdy),
    .pc_sel (pc_sel),
    .reg_en_f (reg_en_f), .reg_en_d (reg_en_d), .reg_en_x (reg_en_x),
    .reg_en_m (reg_en_m), .reg_en_w (reg_en_w),
    .op1_sel_d (op1_sel_d), .alu_fn_x (alu_fn_x), .wb_from_mem_m (wb_from_mem_m),
    .rf_wen_w (rf_wen_w), .rf_waddr_w (rf_waddr_w),
    .bypass_rs (bypass_rs), .bypass_rt (bypass_rt),
    .inst_d (inst_d), .br_cond_eq_x (br_cond_eq_x),
    .br_cond_neg_x (br_cond_neg_x), .br_cond_zero_x (br_cond_zero_x)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //------------------------------
  // Helpers
  //------------------------------
  task automatic check_value(input string test, input string signal,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error: test %0s vector %0d %0s expected %0h actual %0h",
               test, cur_vector, signal, expected, actual);
    end
  endtask

  function automatic logic is_load(input inst_t i);
    return i[OPC_MSB:OPC_LSB] == OPC_LW;
  endfunction

  function automatic logic is_store(input inst_t i);
    return i[OPC_MSB:OPC_LSB] == OPC_SW;
  endfunction

  // Immediate form of each opcode
  function automatic op1_sel_t expected_op1_sel(input inst_t i);
    case (i[OPC_MSB:OPC_LSB])
      OPC_ADDIU, OPC_LW, OPC_SW:  return OP1_SIMM;
      OPC_ORI, OPC_ANDI, OPC_LUI: return OP1_ZIMM;
      default:                    return OP1_REG;
    endcase
  endfunction

  task automatic load_vectors;
    int fd;
    int n;
    logic [8*160-1:0] line;
    string tok;
    logic [31:0] ireq;
    logic [31:0] iresp;
    logic [31:0] dreq;
    logic [31:0] dresp;
    logic [31:0] inst;
    logic [31:0] eq;
    logic [31:0] neg;
    logic [31:0] zero;
    logic [31:0] pc;
    logic [31:0] en;
    logic [31:0] alu;
    logic [31:0] brs;
    logic [31:0] brt;
    logic [31:0] dval;
    logic [31:0] wen;
    logic [31:0] waddr;
    fd = $fopen("verif/proc_ctrl_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file verif/proc_ctrl_vectors.txt");
      error_count++;
    end else begin
      while (!$feof(fd) && num_vectors < MAX_VECTORS) begin
        line = '0;
        n = $fgets(line, fd);
        n = $sscanf(line, "%s", tok);
        if (n == 1 && tok.getc(0) != "#") begin  // Skip blank and comment lines
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      tok, ireq, iresp, dreq, dresp, inst, eq, neg, zero,
                      pc, en, alu, brs, brt, dval, wen, waddr);
          if (n == 17) begin
            stim_mem[num_vectors] = {ireq[0], iresp[0], dreq[0], dresp[0], inst,
                                     eq[0], neg[0], zero[0]};
            exp_mem[num_vectors]  = {pc[0], en[0], alu[3:0], brs[1:0], brt[1:0],
                                     dval[0], wen[0], waddr[4:0]};
            name_mem[num_vectors] = tok;
            num_vectors++;
          end else begin
            $display("Vector file line after vector %0d has the wrong number of fields",
                     num_vectors);
            error_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic apply_stimulus(input stim_t s);
    imemreq_rdy    = s.imemreq_rdy;
    imemresp_val   = s.imemresp_val;
    dmemreq_rdy    = s.dmemreq_rdy;
    dmemresp_val   = s.dmemresp_val;
    inst_d         = s.inst;
    br_cond_eq_x   = s.cond_eq;
    br_cond_neg_x  = s.cond_neg;
    br_cond_zero_x = s.cond_zero;
  endtask

  task automatic compare_outputs(input int idx);
    expect_t e;
    stim_t   s;
    string   t;
    logic    x_valid;
    logic    x_mem;
    logic    m_mem;
    logic    m_stall;
    logic    x_stall;
    e = exp_mem[idx];
    s = stim_mem[idx];
    t = name_mem[idx];
    cur_vector = idx;
    x_valid = (e.alu_fn != ALU_EMPTY);
    x_mem   = x_valid && (is_load(shadow_x_inst) || is_store(shadow_x_inst));
    m_mem   = shadow_m_valid && (is_load(shadow_m_inst) || is_store(shadow_m_inst));
    m_stall = m_mem && !s.dmemresp_val;
    x_stall = m_stall || (x_mem && !s.dmemreq_rdy);

    check_value(t, "pc_sel", e.pc_sel, pc_sel);
    check_value(t, "reg_en_d", e.reg_en_d, reg_en_d);
    if (e.alu_fn != ALU_EMPTY) begin
      check_value(t, "alu_fn_x", e.alu_fn, alu_fn_x);
    end
    check_value(t, "bypass_rs", e.bypass_rs, bypass_rs);
    check_value(t, "bypass_rt", e.bypass_rt, bypass_rt);
    check_value(t, "dmemreq_val", e.dmemreq_val, dmemreq_val);
    if (e.dmemreq_val) begin
      check_value(t, "dmemreq_type",
                  is_store(shadow_x_inst) ? MEM_REQ_WRITE : MEM_REQ_READ, dmemreq_type);
    end
    check_value(t, "rf_wen_w", e.rf_wen, rf_wen_w);
    if (e.rf_wen) begin  // Address only matters on a write
      check_value(t, "rf_waddr_w", e.rf_waddr, rf_waddr_w);
    end

    // Fetch side follows D when the response is there
    if (s.imemresp_val) begin
      check_value(t, "reg_en_f", e.reg_en_d && s.imemreq_rdy, reg_en_f);
      check_value(t, "imemreq_val", e.reg_en_d, imemreq_val);
      check_value(t, "imemresp_rdy", e.reg_en_d, imemresp_rdy);
    end
    check_value(t, "imemresp_drop", e.pc_sel && e.reg_en_d, imemresp_drop);
    check_value(t, "op1_sel_d", expected_op1_sel(s.inst), op1_sel_d);
    check_value(t, "reg_en_x", !x_stall, reg_en_x);
    check_value(t, "reg_en_m", !m_stall, reg_en_m);
    check_value(t, "reg_en_w", 1'b1, reg_en_w);
    check_value(t, "dmemresp_rdy", m_mem, dmemresp_rdy);
    if (shadow_m_valid) begin
      check_value(t, "wb_from_mem_m", is_load(shadow_m_inst), wb_from_mem_m);
    end

    // Advance the shadow for the coming edge
    if (!m_stall) begin
      shadow_m_valid = x_valid && !x_stall;
      shadow_m_inst  = shadow_x_inst;
    end
    if (e.reg_en_d) begin
      shadow_x_inst = s.inst;
    end
  endtask

  //------------------------------
  // Main sequence
  //------------------------------
  initial begin
    error_count    = 0;
    check_count    = 0;
    num_vectors    = 0;
    cur_vector     = 0;
    shadow_x_inst  = '0;
    shadow_m_inst  = '0;
    shadow_m_valid = 1'b0;
    reset          = 1'b1;
    imemreq_rdy    = 1'b1;
    imemresp_val   = 1'b1;
    dmemreq_rdy    = 1'b1;
    dmemresp_val   = 1'b1;
    inst_d         = '0;
    br_cond_eq_x   = 1'b0;
    br_cond_neg_x  = 1'b0;
    br_cond_zero_x = 1'b0;
    load_vectors();
    timeout_limit = RESET_CYCLES + num_vectors + TIMEOUT_SLACK;
    repeat (RESET_CYCLES) @(posedge clk);
    for (int i = 0; i < num_vectors; i++) begin
      if (i > 0) begin
        @(posedge clk);
      end
      #DRIVE_DELAY;
      reset = 1'b0;
      apply_stimulus(stim_mem[i]);
      #(CLK_PERIOD - DRIVE_DELAY - 1);  // Sample just before the next edge
      compare_outputs(i);
    end
    @(posedge clk);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && num_vectors > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Safety net against a stuck run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verif/proc_ctrl_vectors.txt
# name ireq_rdy iresp_val dreq_rdy dresp_val inst_d eq neg zero | expected: pc_sel reg_en_d
# alu_fn_x (f = bubble in X) bypass_rs bypass_rt dmemreq_val rf_wen_w rf_waddr_w
reset      1 1 1 1 00000000 0 0 0   0 1 f 0 0 0 0 00
reset      1 1 1 1 00000000 0 0 0   0 1 f 0 0 0 0 00
decode     1 1 1 1 014B0821 0 0 0   0 1 f 0 0 0 0 00
decode     1 1 1 1 35420005 0 0 0   0 1 0 0 0 0 0 00
decode     1 1 1 1 3C031234 0 0 0   0 1 3 0 0 0 0 00
decode     1 1 1 1 014B2026 0 0 0   0 1 8 0 0 0 1 01
decode     1 1 1 1 014B2821 0 0 0   0 1 4 0 0 0 1 02
bypass     1 1 1 1 00AB3023 0 0 0   0 1 0 1 0 0 1 03
bypass     1 1 1 1 00AB4024 0 0 0   0 1 1 2 0 0 1 04
bypass     1 1 1 1 014B0021 0 0 0   0 1 2 0 0 0 1 05
bypass     1 1 1 1 000B4825 0 0 0   0 1 0 0 0 0 1 06
load_use   1 1 1 1 8D470000 0 0 0   0 1 3 0 0 0 1 08
load_use   1 1 1 1 00EB6021 0 0 0   0 0 0 0 0 1 1 00
load_use   1 1 1 1 00EB6021 0 0 0   0 1 f 2 0 0 1 09
branch     1 1 1 1 114B0004 0 0 0   0 1 0 0 0 0 1 07
branch     1 1 1 1 014B6821 1 0 0   1 1 1 0 0 0 0 00
branch     1 1 1 1 014B7021 0 0 0   0 1 f 0 0 0 1 0c
branch     1 1 1 1 1D400004 0 0 0   0 1 f 0 0 0 0 00
branch     1 1 1 1 014B8021 0 1 0   0 1 0 0 0 0 0 00
branch     1 1 1 1 014B8821 0 0 0   0 1 0 0 0 0 0 00
backpress  1 1 1 1 AD4B0000 0 0 0   0 1 0 0 0 0 0 00
backpress  1 1 0 1 014B9025 0 0 0   0 0 0 0 0 1 1 10
backpress  1 1 0 1 014B9025 0 0 0   0 0 0 0 0 1 1 11
backpress  1 1 1 1 014B9025 0 0 0   0 1 0 0 0 1 0 00
backpress  1 1 1 1 8D4F0000 0 0 0   0 1 3 0 0 0 0 00
backpress  1 1 1 1 014B9826 0 0 0   0 1 0 0 0 1 0 00
backpress  1 1 1 0 014BA825 0 0 0   0 0 4 0 0 0 1 12
backpress  1 1 1 0 014BA825 0 0 0   0 0 4 0 0 0 0 00
backpress  1 1 1 1 014BA825 0 0 0   0 1 4 0 0 0 0 00
drain      1 1 1 1 00000000 0 0 0   0 1 3 0 0 0 1 0f
drain      1 1 1 1 00000000 0 0 0   0 1 f 0 0 0 1 13
drain      1 1 1 1 00000000 0 0 0   0 1 f 0 0 0 1 15
drain      1 1 1 1 00000000 0 0 0   0 1 f 0 0 0 0 00

//--- verilog.f
source/pipe_ctrl_pkg.sv
source/inst_decoder.sv
source/pipe_stage.sv
source/hazard_unit.sv
source/branch_resolve.sv
source/proc_ctrl.sv
verif/proc_ctrl_tb.sv
